// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the array heap testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f tb.f --top-module arrayHeapTb -o arrayHeapSim; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/arrayHeapSim)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qF '*** PASSED ***'; then
  exit 0
else
  exit 1
fi

// ==== tb.f ====
+incdir+testbench
verilog/heapPkg.sv
verilog/requestQueue.sv
verilog/arrayAllocator.sv
verilog/elementStore.sv
verilog/elementAlu.sv
verilog/heapController.sv
verilog/arrayHeap.sv
testbench/arrayHeapTb.sv

// ==== testbench/heapTable.svh ====
// Array heap test table
// Columns: request {opcode, array, index, operand}, expected response {data, status}
`ifndef HEAP_TABLE_SVH
`define HEAP_TABLE_SVH

typedef struct packed {
  heapPkg::heapRequest  request;
  heapPkg::heapResponse expected;
} tableRow;

localparam int numRows = 46;

localparam tableRow testTable [numRows] = '{
  // ----------------------------------------
  // Allocation and access checks
  // ----------------------------------------
  '{'{heapPkg::alloc,      2'd0, 2'd0, 12'h000}, '{12'h000, heapPkg::ok}},
  '{'{heapPkg::read,       2'd3, 2'd0, 12'h000}, '{12'h000, heapPkg::notAllocated}},
  '{'{heapPkg::alloc,      2'd0, 2'd0, 12'h000}, '{12'h001, heapPkg::ok}},
  '{'{heapPkg::alloc,      2'd0, 2'd0, 12'h000}, '{12'h002, heapPkg::ok}},
  '{'{heapPkg::alloc,      2'd0, 2'd0, 12'h000}, '{12'h003, heapPkg::ok}},
  '{'{heapPkg::alloc,      2'd0, 2'd0, 12'h000}, '{12'h000, heapPkg::outOfMemory}},
  '{'{heapPkg::free,       2'd2, 2'd0, 12'h000}, '{12'h000, heapPkg::ok}},
  '{'{heapPkg::free,       2'd1, 2'd0, 12'h000}, '{12'h000, heapPkg::ok}},
  '{'{heapPkg::read,       2'd2, 2'd0, 12'h000}, '{12'h000, heapPkg::freed}},
  '{'{heapPkg::free,       2'd2, 2'd0, 12'h000}, '{12'h000, heapPkg::freed}},  // Double free
  '{'{heapPkg::alloc,      2'd0, 2'd0, 12'h000}, '{12'h001, heapPkg::ok}},     // Last freed first
  '{'{heapPkg::alloc,      2'd0, 2'd0, 12'h000}, '{12'h002, heapPkg::ok}},
  // ----------------------------------------
  // Write, read and size on array 0
  // ----------------------------------------
  '{'{heapPkg::write,      2'd0, 2'd0, 12'h123}, '{12'h123, heapPkg::ok}},
  '{'{heapPkg::write,      2'd0, 2'd2, 12'hABC}, '{12'hABC, heapPkg::ok}},     // Size grows to 3
  '{'{heapPkg::read,       2'd0, 2'd0, 12'h000}, '{12'h123, heapPkg::ok}},
  '{'{heapPkg::read,       2'd0, 2'd2, 12'h000}, '{12'hABC, heapPkg::ok}},
  '{'{heapPkg::size,       2'd0, 2'd0, 12'h000}, '{12'h003, heapPkg::ok}},
  '{'{heapPkg::read,       2'd0, 2'd3, 12'h000}, '{12'h000, heapPkg::outOfBounds}},
  // Stack on array 1
  '{'{heapPkg::push,       2'd1, 2'd0, 12'h011}, '{12'h011, heapPkg::ok}},
  '{'{heapPkg::push,       2'd1, 2'd0, 12'h022}, '{12'h022, heapPkg::ok}},
  '{'{heapPkg::push,       2'd1, 2'd0, 12'h033}, '{12'h033, heapPkg::ok}},
  '{'{heapPkg::push,       2'd1, 2'd0, 12'h044}, '{12'h044, heapPkg::ok}},
  '{'{heapPkg::push,       2'd1, 2'd0, 12'h055}, '{12'h000, heapPkg::full}},
  '{'{heapPkg::pop,        2'd1, 2'd0, 12'h000}, '{12'h044, heapPkg::ok}},
  '{'{heapPkg::pop,        2'd1, 2'd0, 12'h000}, '{12'h033, heapPkg::ok}},
  '{'{heapPkg::pop,        2'd1, 2'd0, 12'h000}, '{12'h022, heapPkg::ok}},
  '{'{heapPkg::pop,        2'd1, 2'd0, 12'h000}, '{12'h011, heapPkg::ok}},
  '{'{heapPkg::pop,        2'd1, 2'd0, 12'h000}, '{12'h000, heapPkg::empty}},
  // ----------------------------------------
  // Read-modify-write on array 0 index 0
  // ----------------------------------------
  '{'{heapPkg::add,        2'd0, 2'd0, 12'hF00}, '{12'h023, heapPkg::ok}},     // 0x1023 wraps
  '{'{heapPkg::read,       2'd0, 2'd0, 12'h000}, '{12'h023, heapPkg::ok}},
  '{'{heapPkg::addAfter,   2'd0, 2'd0, 12'h005}, '{12'h023, heapPkg::ok}},     // Old value back
  '{'{heapPkg::read,       2'd0, 2'd0, 12'h000}, '{12'h028, heapPkg::ok}},
  '{'{heapPkg::subtract,   2'd0, 2'd0, 12'h008}, '{12'h020, heapPkg::ok}},
  '{'{heapPkg::read,       2'd0, 2'd0, 12'h000}, '{12'h020, heapPkg::ok}},
  '{'{heapPkg::shiftLeft,  2'd0, 2'd0, 12'h003}, '{12'h100, heapPkg::ok}},
  '{'{heapPkg::read,       2'd0, 2'd0, 12'h000}, '{12'h100, heapPkg::ok}},
  '{'{heapPkg::shiftRight, 2'd0, 2'd0, 12'h004}, '{12'h010, heapPkg::ok}},
  '{'{heapPkg::read,       2'd0, 2'd0, 12'h000}, '{12'h010, heapPkg::ok}},
  '{'{heapPkg::bitNot,     2'd0, 2'd0, 12'h000}, '{12'hFEF, heapPkg::ok}},     // Operand unused
  '{'{heapPkg::read,       2'd0, 2'd0, 12'h000}, '{12'hFEF, heapPkg::ok}},
  '{'{heapPkg::bitOr,      2'd0, 2'd0, 12'h010}, '{12'hFFF, heapPkg::ok}},
  '{'{heapPkg::read,       2'd0, 2'd0, 12'h000}, '{12'hFFF, heapPkg::ok}},
  '{'{heapPkg::bitXor,     2'd0, 2'd0, 12'h0F0}, '{12'hF0F, heapPkg::ok}},
  '{'{heapPkg::read,       2'd0, 2'd0, 12'h000}, '{12'hF0F, heapPkg::ok}},
  '{'{heapPkg::bitAnd,     2'd0, 2'd0, 12'h3C3}, '{12'h303, heapPkg::ok}},
  '{'{heapPkg::read,       2'd0, 2'd0, 12'h000}, '{12'h303, heapPkg::ok}}
};

`endif

// ==== testbench/arrayHeapTb.sv ====
// Array heap testbench
// Credit-respecting producer feeds the table rows, a randomly slow consumer
// checks every response in order
`timescale 1ns/1ps

module arrayHeapTb;

  localparam int clockPeriod     = 8;                  // ns
  localparam int queueDepth      = 4;
  localparam int responseCredits = 2;
  localparam int seed            = 32'hb9e2;

  `include "heapTable.svh"

  logic                 clock;
  logic                 resetN;
  logic                 reqValid;
  heapPkg::heapRequest  request;
  logic                 reqCredit;
  logic                 respValid;
  heapPkg::heapResponse response;
  logic                 respCredit;

  arrayHeap #(
    .queueDepth(queueDepth),
    .responseCredits(responseCredits)
  ) i_dut (
    .clock, .resetN, .reqValid, .request, .reqCredit,
    .respValid, .response, .respCredit
  );

  // ----------------------------------------
  // Failure and compare tasks
  // ----------------------------------------
  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic checkData(input string name, input heapPkg::elemData expected,
                           input heapPkg::elemData actual);
    if (actual !== expected)
      abortRun($sformatf("ERROR %s data expected %h actual %h", name, expected, actual));
  endtask

  task automatic checkStatus(input string name, input heapPkg::heapStatus expected,
                             input heapPkg::heapStatus actual);
    if (actual !== expected)
      abortRun($sformatf("ERROR %s status expected %s actual %s", name,
                         expected.name(), actual.name()));
  endtask

  // ----------------------------------------
  // Clock, reset, watchdog
  // ----------------------------------------
  initial begin
    clock = 1'b0;
    forever #(clockPeriod / 2) clock = ~clock;
  end

  initial begin
    void'($urandom(seed));                             // One seed for the whole run
    resetN = 1'b0;
    repeat (16) @(posedge clock);
    resetN <= 1'b1;
  end

  initial begin : watchdog
    #(clockPeriod * (16 + 20 * numRows));
    abortRun("Timeout: the DUT did not return all responses in time");
  end

  // ----------------------------------------
  // Producer, spends one credit per request
  // ----------------------------------------
  initial begin : producer
    int next;
    int held;
    reqValid = 1'b0;
    request  = '0;
    next     = 0;
    held     = queueDepth;                             // Queue starts empty
    @(posedge resetN);
    while (next < numRows) begin
      @(posedge clock);
      if (reqCredit)
        held++;                                        // Slot freed in the queue
      if (held > 0) begin
        reqValid <= 1'b1;
        request  <= testTable[next].request;
        held--;
        next++;
      end else begin
        reqValid <= 1'b0;                              // Wait for a credit
      end
    end
    @(posedge clock);
    reqValid <= 1'b0;
  end

  // ----------------------------------------
  // Consumer, checks in order and returns credits late
  // ----------------------------------------
  initial begin : consumer
    int    received;
    int    owed;
    int    holdOff;
    int    available;
    string rowName;
    respCredit = 1'b0;
    received   = 0;
    owed       = 0;
    available  = responseCredits;                      // DUT starts with all credits
    @(posedge resetN);
    holdOff = $urandom % 6;
    while (received < numRows) begin
      @(posedge clock);
      respCredit <= 1'b0;
      if (respValid) begin
        if (available == 0)
          abortRun("A response arrived while the DUT held no response credit");
        available--;
        rowName = $sformatf("row %0d %s", received,
                            testTable[received].request.opcode.name());
        checkData(rowName, testTable[received].expected.data, response.data);
        checkStatus(rowName, testTable[received].expected.status, response.status);
        received++;
        owed++;
      end
      if (owed > 0) begin
        if (holdOff == 0) begin
          respCredit <= 1'b1;                          // One response slot back
          owed--;
          available++;
          holdOff = $urandom % 6;                      // 0 to 5 cycles
        end else begin
          holdOff--;
        end
      end
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== verilog/arrayAllocator.sv ====
// Array allocator
// Live flags, stack of freed arrays and the next-new counter
`timescale 1ns/1ps

module arrayAllocator (
  input  logic             clock,
  input  logic             resetN,
  input  heapPkg::arrayNum array,
  input  logic             allocate,
  input  logic             releaseArray,
  output logic             liveArray,
  output logic             everAllocated,
  output logic             allocOk,
  output heapPkg::arrayNum allocArray
);

  localparam int countBits = heapPkg::addressBits + 1;   // Counts 0 to numArrays

  logic [heapPkg::numArrays-1:0] live;                 // One flag per array
  heapPkg::arrayNum              freedStack [heapPkg::numArrays];
  logic [countBits-1:0]          stackTop;             // Entries on the freed stack
  logic [countBits-1:0]          nextNew;              // First never-used array
  heapPkg::arrayNum              topSlot;
  logic                          stackUsed;

  assign topSlot       = heapPkg::arrayNum'(stackTop - 1'b1);
  assign stackUsed     = stackTop != '0;
  assign liveArray     = live[array];
  assign everAllocated = {1'b0, array} < nextNew;

  // Freed arrays first, last freed comes back first
  assign allocOk    = stackUsed || (nextNew < countBits'(heapPkg::numArrays));
  assign allocArray = stackUsed ? freedStack[topSlot] : heapPkg::arrayNum'(nextNew);

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      live     <= '0;
      stackTop <= '0;
      nextNew  <= '0;
    end else if (allocate && allocOk) begin
      live[allocArray] <= 1'b1;
      if (stackUsed)
        stackTop <= stackTop - 1'b1;                   // Reuse
      else
        nextNew  <= nextNew + 1'b1;                    // Fresh array
    end else if (releaseArray) begin
      live[array] <= 1'b0;
      stackTop    <= stackTop + 1'b1;
    end
  end

  // Stack never overflows, only live arrays are released
  always_ff @(posedge clock) begin
    if (releaseArray)
      freedStack[stackTop[heapPkg::addressBits-1:0]] <= array;
  end

endmodule

// ==== verilog/arrayHeap.sv ====
// Array heap top level
// Request queue feeding the controller, allocator, element store and ALU
`timescale 1ns/1ps

module arrayHeap #(
  parameter int queueDepth      = 4,
  parameter int responseCredits = 2
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 reqValid,
  input  heapPkg::heapRequest  request,
  output logic                 reqCredit,
  output logic                 respValid,
  output heapPkg::heapResponse response,
  input  logic                 respCredit
);

  logic                 headValid;
  heapPkg::heapRequest  head;
  logic                 popHead;
  logic                 liveArray;
  logic                 everAllocated;
  logic                 allocOk;
  heapPkg::arrayNum     allocArray;
  logic                 allocate;
  logic                 releaseArray;
  heapPkg::storeCommand command;
  heapPkg::elemData     element;
  heapPkg::arraySize    size;
  heapPkg::elemData     newValue;
  heapPkg::elemData     resultValue;

  requestQueue #(.queueDepth(queueDepth)) queue (
    .clock, .resetN, .reqValid, .request,
    .pop(popHead), .headValid, .head, .reqCredit
  );

  arrayAllocator allocator (
    .clock, .resetN, .array(head.array), .allocate, .releaseArray,
    .liveArray, .everAllocated, .allocOk, .allocArray
  );

  // Read address shares the command index
  elementStore store (
    .clock, .resetN, .array(head.array), .index(command.index),
    .command, .element, .size
  );

  elementAlu alu (
    .opcode(head.opcode), .element, .operand(head.operand),
    .newValue, .resultValue
  );

  heapController #(.responseCredits(responseCredits)) controller (
    .clock, .resetN, .headValid, .head, .liveArray, .everAllocated,
    .allocOk, .allocArray, .element, .size, .newValue, .resultValue,
    .respCredit, .pop(popHead), .allocate, .releaseArray, .command,
    .respValid, .response
  );

endmodule

// ==== verilog/elementAlu.sv ====
// Element ALU
// New element value and returned value for the read-modify-write opcodes
`timescale 1ns/1ps

module elementAlu (
  input  heapPkg::heapOp   opcode,
  input  heapPkg::elemData element,
  input  heapPkg::elemData operand,
  output heapPkg::elemData newValue,
  output heapPkg::elemData resultValue
);

  always_comb begin
    case (opcode)
      heapPkg::add,
      heapPkg::addAfter:   newValue = element + operand;   // Wraps at dataBits
      heapPkg::subtract:   newValue = element - operand;
      heapPkg::shiftLeft:  newValue = element << operand;  // Large shifts give zero
      heapPkg::shiftRight: newValue = element >> operand;
      heapPkg::bitNot:     newValue = ~element;
      heapPkg::bitOr:      newValue = element | operand;
      heapPkg::bitXor:     newValue = element ^ operand;
      heapPkg::bitAnd:     newValue = element & operand;
      default:             newValue = element;             // Not an arithmetic opcode
    endcase
  end

  // Previous value only for addAfter
  assign resultValue = (opcode == heapPkg::addAfter) ? element : newValue;

endmodule

// ==== verilog/elementStore.sv ====
// Element store
// Element memory of all arrays plus one size register per array
`timescale 1ns/1ps

module elementStore (
  input  logic                 clock,
  input  logic                 resetN,
  input  heapPkg::arrayNum     array,
  input  heapPkg::elemIndex    index,
  input  heapPkg::storeCommand command,
  output heapPkg::elemData     element,
  output heapPkg::arraySize    size
);

  // ----------------------------------------
  // Storage
  // ----------------------------------------
  heapPkg::elemData  memory [heapPkg::numArrays][heapPkg::arrayLength];
  heapPkg::arraySize sizes  [heapPkg::numArrays];

  // Combinational read of the addressed array
  assign element = memory[array][index];
  assign size    = sizes[array];

  // ----------------------------------------
  // Updates
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (command.writeEnable)
      memory[command.array][command.index] <= command.data;
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int a = 0; a < heapPkg::numArrays; a++) begin
        sizes[a] <= '0;                                // Every array starts empty
      end
    end else if (command.sizeEnable) begin
      sizes[command.array] <= command.newSize;
    end
  end

endmodule

// ==== verilog/heapController.sv ====
// Heap controller
// Executes the queue head: legality checks, allocator and store updates,
// registered response and response credit count
`timescale 1ns/1ps

module heapController #(
  parameter int responseCredits = 2
) (
  input  logic                  clock,
  input  logic                  resetN,
  input  logic                  headValid,
  input  heapPkg::heapRequest   head,
  input  logic                  liveArray,
  input  logic                  everAllocated,
  input  logic                  allocOk,
  input  heapPkg::arrayNum      allocArray,
  input  heapPkg::elemData      element,
  input  heapPkg::arraySize     size,
  input  heapPkg::elemData      newValue,
  input  heapPkg::elemData      resultValue,
  input  logic                  respCredit,
  output logic                  pop,
  output logic                  allocate,
  output logic                  releaseArray,
  output heapPkg::storeCommand  command,
  output logic                  respValid,
  output heapPkg::heapResponse  response
);

  localparam int creditBits = $clog2(responseCredits + 1);

  logic [creditBits-1:0] credits;                      // Responses we may still send
  logic                  execute;
  logic                  legal;
  logic                  isArith;
  heapPkg::heapStatus    respStatus;
  heapPkg::elemData      respData;

  assign execute      = headValid && (credits != '0);  // Stall on zero credits
  assign pop          = execute;
  assign isArith      = head.opcode >= heapPkg::add;
  assign legal        = execute && (respStatus == heapPkg::ok);
  assign allocate     = legal && (head.opcode == heapPkg::alloc);
  assign releaseArray = legal && (head.opcode == heapPkg::free);

  // ----------------------------------------
  // Legality checks, in priority order
  // ----------------------------------------
  always_comb begin
    respStatus = heapPkg::ok;
    if (head.opcode == heapPkg::alloc) begin
      if (!allocOk)
        respStatus = heapPkg::outOfMemory;
    end else if (!everAllocated) begin
      respStatus = heapPkg::notAllocated;
    end else if (!liveArray) begin
      respStatus = heapPkg::freed;
    end else if ((isArith || head.opcode == heapPkg::read) && {1'b0, head.index} >= size) begin
      respStatus = heapPkg::outOfBounds;
    end else if (head.opcode == heapPkg::push &&
                 size == heapPkg::arraySize'(heapPkg::arrayLength)) begin
      respStatus = heapPkg::full;
    end else if (head.opcode == heapPkg::pop && size == '0) begin
      respStatus = heapPkg::empty;
    end
  end

  // ----------------------------------------
  // Store command and returned data
  // ----------------------------------------
  always_comb begin
    command       = '0;
    command.array = head.array;
    command.index = head.index;                        // Also steers the element read
    respData      = '0;
    case (head.opcode)
      heapPkg::alloc: begin
        respData           = heapPkg::elemData'(allocArray);
        command.array      = allocArray;
        command.sizeEnable = 1'b1;                     // New array starts empty
      end
      heapPkg::free: respData = '0;
      heapPkg::write: begin
        respData            = head.operand;
        command.writeEnable = 1'b1;
        command.data        = head.operand;
        command.sizeEnable  = {1'b0, head.index} >= size;  // Grow only
        command.newSize     = heapPkg::arraySize'(head.index) + 1'b1;
      end
      heapPkg::read: respData = element;
      heapPkg::size: respData = heapPkg::elemData'(size);
      heapPkg::push: begin
        respData            = head.operand;
        command.index       = size[heapPkg::indexBits-1:0];
        command.writeEnable = 1'b1;
        command.data        = head.operand;
        command.sizeEnable  = 1'b1;
        command.newSize     = size + 1'b1;
      end
      heapPkg::pop: begin
        respData           = element;                  // Element at the new size
        command.index      = heapPkg::elemIndex'(size - 1'b1);
        command.sizeEnable = 1'b1;
        command.newSize    = size - 1'b1;
      end
      default: begin                                   // Read-modify-write group
        respData            = resultValue;
        command.writeEnable = 1'b1;
        command.data        = newValue;
      end
    endcase
    if (!legal) begin
      command.writeEnable = 1'b0;                      // Errors change nothing
      command.sizeEnable  = 1'b0;
      respData            = '0;
    end
  end

  // ----------------------------------------
  // Response register and credits
  // ----------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      respValid <= 1'b0;
      credits   <= creditBits'(responseCredits);
    end else begin
      respValid <= execute;
      credits   <= credits - creditBits'(execute) + creditBits'(respCredit);
    end
  end

  always_ff @(posedge clock) begin
    if (execute)
      response <= '{data: respData, status: respStatus};
  end

endmodule

// ==== verilog/heapPkg.sv ====
// Array heap shared definitions
// Widths, opcodes, status codes and the structs passed between blocks
package heapPkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------
  parameter int addressBits = 2;                     // Bits in an array number
  parameter int numArrays   = 4;                     // Arrays in the pool
  parameter int indexBits   = 2;                     // Bits in an element index
  parameter int arrayLength = 4;                     // Elements per array
  parameter int dataBits    = 12;                    // Element width
  parameter int sizeBits    = indexBits + 1;         // Size runs 0 to arrayLength

  typedef logic [addressBits-1:0] arrayNum;
  typedef logic [indexBits-1:0]   elemIndex;
  typedef logic [dataBits-1:0]    elemData;
  typedef logic [sizeBits-1:0]    arraySize;

  // ----------------------------------------
  // Encodings
  // ----------------------------------------
  typedef enum logic [3:0] {
    alloc, free, write, read, size, push, pop,       // Pool and access
    add, addAfter, subtract, shiftLeft, shiftRight,  // Read-modify-write from add onwards
    bitNot, bitOr, bitXor, bitAnd
  } heapOp;

  typedef enum logic [2:0] {
    ok, notAllocated, freed, outOfBounds, full, empty, outOfMemory
  } heapStatus;

  // ----------------------------------------
  // Bundles
  // ----------------------------------------
  typedef struct packed {
    heapOp    opcode;
    arrayNum  array;
    elemIndex index;
    elemData  operand;                               // Write value or arithmetic operand
  } heapRequest;

  typedef struct packed {
    elemData   data;                                 // Zero on any error
    heapStatus status;
  } heapResponse;

  typedef struct packed {
    logic     writeEnable;                           // One element write
    arrayNum  array;
    elemIndex index;                                 // Also the element read address
    elemData  data;
    logic     sizeEnable;                            // One size update
    arraySize newSize;
  } storeCommand;

endpackage

// ==== verilog/requestQueue.sv ====
// Request queue
// Circular FIFO in front of the controller; returns one credit per pop
`timescale 1ns/1ps

module requestQueue #(
  parameter int queueDepth = 4
) (
  input  logic                clock,
  input  logic                resetN,
  input  logic                reqValid,
  input  heapPkg::heapRequest request,
  input  logic                pop,
  output logic                headValid,
  output heapPkg::heapRequest head,
  output logic                reqCredit
);

  localparam int ptrBits   = (queueDepth > 1) ? $clog2(queueDepth) : 1;
  localparam int countBits = $clog2(queueDepth + 1);

  heapPkg::heapRequest  slots [queueDepth];          // Request storage
  logic [ptrBits-1:0]   wrPtr;
  logic [ptrBits-1:0]   rdPtr;
  logic [countBits-1:0] count;                       // Occupancy, producer never overfills

  assign headValid = count != '0;
  assign head      = slots[rdPtr];

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      count     <= '0;
      reqCredit <= 1'b0;
    end else begin
      if (reqValid)
        wrPtr <= (wrPtr == ptrBits'(queueDepth - 1)) ? '0 : wrPtr + 1'b1;
      if (pop)
        rdPtr <= (rdPtr == ptrBits'(queueDepth - 1)) ? '0 : rdPtr + 1'b1;
      count     <= count + countBits'(reqValid) - countBits'(pop);
      reqCredit <= pop;                              // Slot freed, hand credit back
    end
  end

  always_ff @(posedge clock) begin
    if (reqValid)
      slots[wrPtr] <= request;
  end

endmodule
